/* design/gem_match_pkg.sv */
`default_nettype none

package gem_match_pkg;

  typedef logic [9:0] strip_t;  // position on the common half-strip scale
  typedef logic [9:0] angle_t;  // bending angle between CLCT key and GEM pad
  typedef logic [2:0] win_t;    // GEM window index

  localparam int NUM_WIN = 8;  // the encoder tree is built for exactly eight windows

  localparam angle_t ANGLE_NONE = 10'h3ff;  // reserved angle, window empty or no match

  // request side handshake of the input stage
  typedef enum logic [1:0] {
    in_idle,     // waiting for req and a free result slot
    in_acked,    // request captured, launch is high for this cycle
    in_wait_low  // ack held high until the producer drops req
  } in_state_t;

  // result side handshake of the output stage
  typedef enum logic [1:0] {
    out_idle,     // waiting for the FIFO to hold a result
    out_req,      // res_req high, head entry presented
    out_wait_low  // entry popped, waiting for res_ack to fall
  } out_state_t;

endpackage

`default_nettype wire

/* design/match_input_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module match_input_stage (
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              req,
  output logic                              ack,
  input  gem_match_pkg::strip_t             clct_key,
  input  gem_match_pkg::strip_t             gem_pad_0,
  input  gem_match_pkg::strip_t             gem_pad_1,
  input  gem_match_pkg::strip_t             gem_pad_2,
  input  gem_match_pkg::strip_t             gem_pad_3,
  input  gem_match_pkg::strip_t             gem_pad_4,
  input  gem_match_pkg::strip_t             gem_pad_5,
  input  gem_match_pkg::strip_t             gem_pad_6,
  input  gem_match_pkg::strip_t             gem_pad_7,
  input  logic [gem_match_pkg::NUM_WIN-1:0] gem_valid,
  input  logic                              slot_free,
  output logic                              launch,
  output gem_match_pkg::strip_t             key_q,
  output gem_match_pkg::strip_t             pad_q_0,
  output gem_match_pkg::strip_t             pad_q_1,
  output gem_match_pkg::strip_t             pad_q_2,
  output gem_match_pkg::strip_t             pad_q_3,
  output gem_match_pkg::strip_t             pad_q_4,
  output gem_match_pkg::strip_t             pad_q_5,
  output gem_match_pkg::strip_t             pad_q_6,
  output gem_match_pkg::strip_t             pad_q_7,
  output logic [gem_match_pkg::NUM_WIN-1:0] valid_q
);
  import gem_match_pkg::*;

  in_state_t state;   // four-phase request handshake
  logic      accept;  // take the request on this edge

  // only accept from idle, and only when the output stage has a slot reserved for us
  assign accept = (state == in_idle) && req && slot_free;
  assign launch = (state == in_acked);  // exactly one cycle per accepted request

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      state <= in_idle;
      ack   <= 1'b0;
    end
    else
    begin
      case (state)
        in_idle:
        begin
          if (accept)
          begin
            state <= in_acked;
            ack   <= 1'b1;  // ack rises on the same edge as the capture
          end
        end
        in_acked:
          state <= in_wait_low;  // launch cycle is over
        in_wait_low:
        begin
          if (!req)
          begin
            ack   <= 1'b0;  // producer released req, finish the four phases
            state <= in_idle;
          end
        end
        default:
          state <= in_idle;
      endcase
    end
  end

  // the producer keeps the data stable while req is high, so one capture is enough
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      key_q   <= clct_key;
      pad_q_0 <= gem_pad_0;
      pad_q_1 <= gem_pad_1;
      pad_q_2 <= gem_pad_2;
      pad_q_3 <= gem_pad_3;
      pad_q_4 <= gem_pad_4;
      pad_q_5 <= gem_pad_5;
      pad_q_6 <= gem_pad_6;
      pad_q_7 <= gem_pad_7;
      valid_q <= gem_valid;
    end
  end

endmodule

`default_nettype wire

/* design/gem_bend_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_bend_calc (
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              launch,
  input  gem_match_pkg::strip_t             key_q,
  input  gem_match_pkg::strip_t             pad_q_0,
  input  gem_match_pkg::strip_t             pad_q_1,
  input  gem_match_pkg::strip_t             pad_q_2,
  input  gem_match_pkg::strip_t             pad_q_3,
  input  gem_match_pkg::strip_t             pad_q_4,
  input  gem_match_pkg::strip_t             pad_q_5,
  input  gem_match_pkg::strip_t             pad_q_6,
  input  gem_match_pkg::strip_t             pad_q_7,
  input  logic [gem_match_pkg::NUM_WIN-1:0] valid_q,
  output logic                              angle_valid,
  output gem_match_pkg::angle_t             angle_0,
  output gem_match_pkg::angle_t             angle_1,
  output gem_match_pkg::angle_t             angle_2,
  output gem_match_pkg::angle_t             angle_3,
  output gem_match_pkg::angle_t             angle_4,
  output gem_match_pkg::angle_t             angle_5,
  output gem_match_pkg::angle_t             angle_6,
  output gem_match_pkg::angle_t             angle_7,
  output gem_match_pkg::strip_t             pad_d_0,
  output gem_match_pkg::strip_t             pad_d_1,
  output gem_match_pkg::strip_t             pad_d_2,
  output gem_match_pkg::strip_t             pad_d_3,
  output gem_match_pkg::strip_t             pad_d_4,
  output gem_match_pkg::strip_t             pad_d_5,
  output gem_match_pkg::strip_t             pad_d_6,
  output gem_match_pkg::strip_t             pad_d_7
);
  import gem_match_pkg::*;

  // absolute key-to-pad distance, empty windows get the reserved angle so they always lose
  function automatic angle_t bend_angle(input strip_t key, input strip_t pad, input logic vld);
    angle_t diff;
    if (key >= pad)
      diff = key - pad;
    else
      diff = pad - key;
    return vld ? diff : ANGLE_NONE;
  endfunction

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      angle_valid <= 1'b0;
    else
      angle_valid <= launch;  // angles are ready one cycle after launch
  end

  always_ff @(posedge clock)
  begin
    if (launch)
    begin
      angle_0 <= bend_angle(key_q, pad_q_0, valid_q[0]);
      angle_1 <= bend_angle(key_q, pad_q_1, valid_q[1]);
      angle_2 <= bend_angle(key_q, pad_q_2, valid_q[2]);
      angle_3 <= bend_angle(key_q, pad_q_3, valid_q[3]);
      angle_4 <= bend_angle(key_q, pad_q_4, valid_q[4]);
      angle_5 <= bend_angle(key_q, pad_q_5, valid_q[5]);
      angle_6 <= bend_angle(key_q, pad_q_6, valid_q[6]);
      angle_7 <= bend_angle(key_q, pad_q_7, valid_q[7]);
      pad_d_0 <= pad_q_0;  // pads ride along so the winner's position is at hand
      pad_d_1 <= pad_q_1;
      pad_d_2 <= pad_q_2;
      pad_d_3 <= pad_q_3;
      pad_d_4 <= pad_q_4;
      pad_d_5 <= pad_q_5;
      pad_d_6 <= pad_q_6;
      pad_d_7 <= pad_q_7;
    end
  end

endmodule

`default_nettype wire

/* design/best_match_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module best_match_encoder (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  angle_valid,
  input  gem_match_pkg::angle_t angle_0,
  input  gem_match_pkg::angle_t angle_1,
  input  gem_match_pkg::angle_t angle_2,
  input  gem_match_pkg::angle_t angle_3,
  input  gem_match_pkg::angle_t angle_4,
  input  gem_match_pkg::angle_t angle_5,
  input  gem_match_pkg::angle_t angle_6,
  input  gem_match_pkg::angle_t angle_7,
  input  gem_match_pkg::strip_t pad_d_0,
  input  gem_match_pkg::strip_t pad_d_1,
  input  gem_match_pkg::strip_t pad_d_2,
  input  gem_match_pkg::strip_t pad_d_3,
  input  gem_match_pkg::strip_t pad_d_4,
  input  gem_match_pkg::strip_t pad_d_5,
  input  gem_match_pkg::strip_t pad_d_6,
  input  gem_match_pkg::strip_t pad_d_7,
  output logic                  best_valid,
  output gem_match_pkg::win_t   best_win,
  output gem_match_pkg::angle_t best_angle,
  output gem_match_pkg::strip_t best_pad
);
  import gem_match_pkg::*;

  angle_t ang    [NUM_WIN];    // window angles in index order
  strip_t pad    [NUM_WIN];
  angle_t pri_s1 [NUM_WIN/2];  // pair winners of level one
  strip_t pad_s1 [NUM_WIN/2];
  logic   bit_s1 [NUM_WIN/2];  // set when the odd window of the pair won

  assign ang = '{angle_0, angle_1, angle_2, angle_3, angle_4, angle_5, angle_6, angle_7};
  assign pad = '{pad_d_0, pad_d_1, pad_d_2, pad_d_3, pad_d_4, pad_d_5, pad_d_6, pad_d_7};

  // odd window must be strictly better, a tie stays with the even one
  for (genvar p = 0; p < NUM_WIN/2; p++)
  begin : g_pair
    assign bit_s1[p] = (ang[2*p+1] < ang[2*p]);
    assign pri_s1[p] = bit_s1[p] ? ang[2*p+1] : ang[2*p];
    assign pad_s1[p] = bit_s1[p] ? pad[2*p+1] : pad[2*p];
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      best_valid <= 1'b0;
    else
      best_valid <= angle_valid;  // result one cycle behind the angles
  end

  // a higher pair only wins when it beats every lower pair, giving the first minimum
  always_ff @(posedge clock)
  begin
    if (angle_valid)
    begin
      if ((pri_s1[3] < pri_s1[2]) && (pri_s1[3] < pri_s1[1]) && (pri_s1[3] < pri_s1[0]))
      begin
        best_angle <= pri_s1[3];
        best_win   <= {2'd3, bit_s1[3]};  // pair number above the pair bit
        best_pad   <= pad_s1[3];
      end
      else if ((pri_s1[2] < pri_s1[1]) && (pri_s1[2] < pri_s1[0]))
      begin
        best_angle <= pri_s1[2];
        best_win   <= {2'd2, bit_s1[2]};
        best_pad   <= pad_s1[2];
      end
      else if (pri_s1[1] < pri_s1[0])
      begin
        best_angle <= pri_s1[1];
        best_win   <= {2'd1, bit_s1[1]};
        best_pad   <= pad_s1[1];
      end
      else
      begin
        best_angle <= pri_s1[0];  // all-invalid lands here with window 0 and ANGLE_NONE
        best_win   <= {2'd0, bit_s1[0]};
        best_pad   <= pad_s1[0];
      end
    end
  end

endmodule

`default_nettype wire

/* design/match_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module match_output_stage #(
  parameter int RESULT_DEPTH = 4
) (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  launch,
  input  logic                  best_valid,
  input  gem_match_pkg::win_t   best_win,
  input  gem_match_pkg::angle_t best_angle,
  input  gem_match_pkg::strip_t best_pad,
  output logic                  slot_free,
  output logic                  res_req,
  input  logic                  res_ack,
  output gem_match_pkg::win_t   res_win,
  output gem_match_pkg::angle_t res_angle,
  output gem_match_pkg::strip_t res_pad
);
  import gem_match_pkg::*;

  localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
  localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

  win_t             win_mem   [RESULT_DEPTH];  // result FIFO storage
  angle_t           angle_mem [RESULT_DEPTH];
  strip_t           pad_mem   [RESULT_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill_cnt;  // entries held in the FIFO
  logic [CNT_W-1:0] rsv_cnt;   // FIFO entries plus results still in the pipeline
  out_state_t       state;
  logic             pop;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(RESULT_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign pop       = (state == out_req) && res_ack;  // consumer took the head entry
  assign slot_free = (rsv_cnt < CNT_W'(RESULT_DEPTH));
  assign res_req   = (state == out_req);
  assign res_win   = win_mem[rd_ptr];  // head stays put until the pop that drops res_req
  assign res_angle = angle_mem[rd_ptr];
  assign res_pad   = pad_mem[rd_ptr];

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
      rsv_cnt  <= '0;
      state    <= out_idle;
    end
    else
    begin
      if (best_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (best_valid && !pop)
        fill_cnt <= fill_cnt + 1'b1;
      else if (!best_valid && pop)
        fill_cnt <= fill_cnt - 1'b1;
      if (launch && !pop)
        rsv_cnt <= rsv_cnt + 1'b1;  // slot reserved as soon as a request enters
      else if (!launch && pop)
        rsv_cnt <= rsv_cnt - 1'b1;
      case (state)
        out_idle:
          if (fill_cnt != '0)
            state <= out_req;  // res_req rises one cycle after the FIFO fills
        out_req:
          if (pop)
            state <= out_wait_low;
        out_wait_low:
          if (!res_ack)
            state <= out_idle;  // next res_req only after res_ack is seen low
        default:
          state <= out_idle;
      endcase
    end
  end

  // reservation keeps the FIFO from ever being written while full
  always_ff @(posedge clock)
  begin
    if (best_valid)
    begin
      win_mem[wr_ptr]   <= best_win;
      angle_mem[wr_ptr] <= best_angle;
      pad_mem[wr_ptr]   <= best_pad;
    end
  end

endmodule

`default_nettype wire

/* design/gem_clct_match_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_clct_match_top #(
  parameter int RESULT_DEPTH = 4
) (
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              req,
  output logic                              ack,
  input  gem_match_pkg::strip_t             clct_key,
  input  gem_match_pkg::strip_t             gem_pad_0,
  input  gem_match_pkg::strip_t             gem_pad_1,
  input  gem_match_pkg::strip_t             gem_pad_2,
  input  gem_match_pkg::strip_t             gem_pad_3,
  input  gem_match_pkg::strip_t             gem_pad_4,
  input  gem_match_pkg::strip_t             gem_pad_5,
  input  gem_match_pkg::strip_t             gem_pad_6,
  input  gem_match_pkg::strip_t             gem_pad_7,
  input  logic [gem_match_pkg::NUM_WIN-1:0] gem_valid,
  output logic                              res_req,
  input  logic                              res_ack,
  output gem_match_pkg::win_t               res_win,
  output gem_match_pkg::angle_t             res_angle,
  output gem_match_pkg::strip_t             res_pad
);
  import gem_match_pkg::*;

  logic               slot_free;    // output stage grants a new request
  logic               launch;       // one pulse per accepted request
  logic               angle_valid;  // angles ready, one cycle after launch
  logic               best_valid;   // best match ready, two cycles after launch
  strip_t             key_q;
  strip_t             pad_q_0, pad_q_1, pad_q_2, pad_q_3, pad_q_4, pad_q_5, pad_q_6, pad_q_7;
  logic [NUM_WIN-1:0] valid_q;
  angle_t             angle_0, angle_1, angle_2, angle_3, angle_4, angle_5, angle_6, angle_7;
  strip_t             pad_d_0, pad_d_1, pad_d_2, pad_d_3, pad_d_4, pad_d_5, pad_d_6, pad_d_7;
  win_t               best_win;
  angle_t             best_angle;
  strip_t             best_pad;

  // stage ports share their names with these nets, so the links connect by name
  match_input_stage u_input (.*);

  gem_bend_calc u_bend (.*);

  best_match_encoder u_encoder (.*);

  match_output_stage #(
    .RESULT_DEPTH (RESULT_DEPTH)  // depth also bounds the requests in flight
  ) u_output (.*);

endmodule

`default_nettype wire

/* test/gem_clct_match_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_clct_match_sva (
  input logic                  clock,
  input logic                  rst_n,
  input logic                  req,
  input logic                  ack,
  input logic                  res_req,
  input logic                  res_ack,
  input gem_match_pkg::win_t   res_win,
  input gem_match_pkg::angle_t res_angle,
  input gem_match_pkg::strip_t res_pad
);

  // ack only ever answers a pending request
  ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n) $rose(ack) |-> req)
    else $error("ack rose while req was low");

  // once raised, res_req waits for the consumer
  res_req_held: assert property (@(posedge clock) disable iff (!rst_n)
    res_req && !res_ack |=> res_req)
    else $error("res_req fell before res_ack was seen");

  // the consumer may sample the result at any point while res_req is high
  res_data_stable: assert property (@(posedge clock) disable iff (!rst_n)
    res_req && !res_ack |=> $stable({res_win, res_angle, res_pad}))
    else $error("result outputs changed while res_req was high");

endmodule

bind gem_clct_match_top gem_clct_match_sva u_sva (.*);

`default_nettype wire

/* test/tb_gem_clct_match.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gem_clct_match;
  import gem_match_pkg::*;

  localparam int MAX_CASES = 64;
  localparam int TIMEOUT   = 500;  // cycles allowed for any single wait
  localparam int STALL_AT  = 3;    // this result is held back long enough to fill the FIFO
  localparam int STALL_LEN = 40;

  logic               clock;
  logic               rst_n;
  logic               req;
  logic               ack;
  strip_t             clct_key;
  strip_t             gem_pad_0, gem_pad_1, gem_pad_2, gem_pad_3;
  strip_t             gem_pad_4, gem_pad_5, gem_pad_6, gem_pad_7;
  logic [NUM_WIN-1:0] gem_valid;
  logic               res_req;
  logic               res_ack;
  win_t               res_win;
  angle_t             res_angle;
  strip_t             res_pad;

  string              name_tab  [MAX_CASES];  // one entry per case line, in request order
  strip_t             key_tab   [MAX_CASES];
  strip_t             pad_tab   [MAX_CASES][NUM_WIN];
  logic [NUM_WIN-1:0] mask_tab  [MAX_CASES];
  win_t               exp_win   [MAX_CASES];
  angle_t             exp_angle [MAX_CASES];
  strip_t             exp_pad   [MAX_CASES];
  int                 num_cases;
  int                 value_errors;
  int                 other_errors;
  int                 full_cycles = 0;  // cycles with no free result slot
  logic               timed_out;        // a wait ran out, so the remaining cases are skipped
  integer             seed;

  gem_clct_match_top #(
    .RESULT_DEPTH (4)
  ) dut (.*);

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns period
  end

  always @(posedge clock)
  begin
    if (rst_n && !dut.slot_free)
      full_cycles <= full_cycles + 1;  // shows that back-pressure really happened
  end

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  task automatic report_timeout(input string msg);
    other_errors++;
    timed_out = 1'b1;
    $display("%s", msg);
  endtask

  task automatic check_field(input int idx, input string field, input int expected,
                             input int actual);
    assert (actual == expected)
    else
    begin
      value_errors++;
      $display("Error %s: %s expected %0d actual %0d", name_tab[idx], field, expected, actual);
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    int    j;
    int    f [13];
    string line;
    string name;
    fd = $fopen("test/gem_match_cases.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("could not open the case file test/gem_match_cases.txt");
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.len() > 1 && line.getc(0) != "#" && num_cases < MAX_CASES)  // skip notes
        begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %h %d %d %d", name, f[0], f[1],
                      f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
          if (n == 14)
          begin
            name_tab[num_cases] = name;
            key_tab[num_cases]  = strip_t'(f[0]);
            for (j = 0; j < NUM_WIN; j++)
              pad_tab[num_cases][j] = strip_t'(f[1+j]);
            mask_tab[num_cases]  = f[9][NUM_WIN-1:0];
            exp_win[num_cases]   = win_t'(f[10]);
            exp_angle[num_cases] = angle_t'(f[11]);
            exp_pad[num_cases]   = strip_t'(f[12]);
            num_cases++;
          end
          else
          begin
            other_errors++;
            $display("malformed line in the case file: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (num_cases == 0)
    begin
      other_errors++;
      $display("no test cases were loaded");
    end
  endtask

  // one full four-phase request, called just after a rising edge
  task automatic send_case(input int idx);
    int cnt;
    clct_key  <= key_tab[idx];
    gem_pad_0 <= pad_tab[idx][0];
    gem_pad_1 <= pad_tab[idx][1];
    gem_pad_2 <= pad_tab[idx][2];
    gem_pad_3 <= pad_tab[idx][3];
    gem_pad_4 <= pad_tab[idx][4];
    gem_pad_5 <= pad_tab[idx][5];
    gem_pad_6 <= pad_tab[idx][6];
    gem_pad_7 <= pad_tab[idx][7];
    gem_valid <= mask_tab[idx];
    req       <= 1'b1;
    cnt = 0;
    @(posedge clock);
    while (!ack && cnt < TIMEOUT)  // ack waits for a free slot when the FIFO is full
    begin
      @(posedge clock);
      cnt++;
    end
    if (!ack)
      report_timeout($sformatf("request of case %s was never acknowledged", name_tab[idx]));
    else
    begin
      req <= 1'b0;
      cnt = 0;
      while (ack && cnt < TIMEOUT)
      begin
        @(posedge clock);
        cnt++;
      end
      if (ack)
        report_timeout($sformatf("ack stayed high after case %s released req",
                                 name_tab[idx]));
    end
  endtask

  task automatic send_all();
    int i;
    for (i = 0; i < num_cases && !timed_out; i++)
      send_case(i);
  endtask

  // consumer side, results must arrive in request order
  task automatic take_results();
    int got;
    int cnt;
    int delay;
    for (got = 0; got < num_cases && !timed_out; got++)
    begin
      cnt = 0;
      while (!res_req && cnt < TIMEOUT)
      begin
        @(posedge clock);
        cnt++;
      end
      if (!res_req)
        report_timeout($sformatf("no result arrived for case %s", name_tab[got]));
      else
      begin
        check_field(got, "window", int'(exp_win[got]), int'(res_win));
        check_field(got, "angle", int'(exp_angle[got]), int'(res_angle));
        check_field(got, "pad", int'(exp_pad[got]), int'(res_pad));
        delay = int'($unsigned($random(seed)) % 16);
        if (got == STALL_AT)
          delay = delay + STALL_LEN;  // long stall lets the producer run into a full FIFO
        repeat (delay) @(posedge clock);
        res_ack <= 1'b1;
        cnt = 0;
        @(posedge clock);
        while (res_req && cnt < TIMEOUT)
        begin
          @(posedge clock);
          cnt++;
        end
        if (res_req)
          report_timeout($sformatf("res_req stayed high after res_ack for case %s",
                                   name_tab[got]));
        else
          res_ack <= 1'b0;
      end
    end
  endtask

  initial
  begin
    rst_n     <= 1'b0;
    req       <= 1'b0;
    res_ack   <= 1'b0;
    clct_key  <= '0;
    gem_pad_0 <= '0;
    gem_pad_1 <= '0;
    gem_pad_2 <= '0;
    gem_pad_3 <= '0;
    gem_pad_4 <= '0;
    gem_pad_5 <= '0;
    gem_pad_6 <= '0;
    gem_pad_7 <= '0;
    gem_valid <= '0;
    seed         = 32'h5626;
    value_errors = 0;
    other_errors = 0;
    num_cases    = 0;
    timed_out    = 1'b0;
    load_cases();
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;
    repeat (6)
    begin
      @(posedge clock);
      assert (!ack && !res_req)  // nothing may come out before the first request
      else
      begin
        other_errors++;
        $display("ack or res_req was high after reset with no request sent");
      end
    end
    fork
      send_all();
      take_results();
    join
    repeat (10)
    begin
      @(posedge clock);
      assert (!res_req)
      else
      begin
        other_errors++;
        $display("an extra result appeared after all cases were answered");
      end
    end
    assert (full_cycles > 0)
    else
    begin
      other_errors++;
      $display("the result FIFO never filled, so back-pressure was not exercised");
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* test/gem_match_cases.txt */
# name key pad0 pad1 pad2 pad3 pad4 pad5 pad6 pad7 mask exp_win exp_angle exp_pad
# key and pads in decimal half-strips, mask in hex with bit n enabling window n
smallest_mid 100 10 50 90 105 130 200 300 400 ff 3 5 105
smallest_w7 500 0 100 200 300 400 450 480 498 ff 7 2 498
smallest_w0 20 21 40 60 80 100 120 140 160 ff 0 1 21
tie_in_pair 200 300 300 190 210 500 500 500 500 ff 2 10 190
tie_across_pairs 300 0 0 0 320 0 280 0 320 ff 3 20 320
tie_odd_vs_even 600 0 610 590 0 0 0 0 0 ff 1 10 610
one_valid_w7 100 100 101 500 500 500 500 500 150 80 7 50 150
invalid_best 400 400 402 350 0 0 0 0 410 fe 1 2 402
all_invalid 123 1 2 3 4 5 6 7 8 00 0 1023 1
far_pads 1022 0 1 2 3 4 5 6 7 03 1 1021 1
key_zero 0 900 800 700 600 500 400 300 250 ff 7 250 250
exact_hit 512 1 2 3 4 512 6 7 8 ff 4 0 512
odd_mask_tie 50 60 40 60 40 60 40 60 40 aa 1 10 40
single_w4 700 0 0 0 0 699 0 0 0 10 4 1 699
mixed_mask 333 320 345 330 340 336 400 300 331 5b 4 3 336
pair_tie_low 10 8 12 9 11 30 40 50 60 ff 2 1 9

/* compile.f */
design/gem_match_pkg.sv
design/match_input_stage.sv
design/gem_bend_calc.sv
design/best_match_encoder.sv
design/match_output_stage.sv
design/gem_clct_match_top.sv
test/gem_clct_match_sva.sv
test/tb_gem_clct_match.sv

/* run_sim.sh */
#!/bin/sh
# Builds the GEM-CLCT match testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_gem_clct_match -f compile.f -o sim_gem_clct_match; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_gem_clct_match > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi

exit 0
